//--- Bender.yml
package:
  name: crossroad_renderer

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/crossroad_pkg.sv
      - rtl/pixel_delay.sv
      - rtl/pixel_sampler.sv
      - rtl/road_layer.sv
      - rtl/signal_car_layer.sv
      - rtl/hud_digits.sv
      - rtl/pixel_compositor.sv
      - rtl/crossroad_renderer.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/tb_crossroad_renderer.sv

//--- rtl/crossroad_pkg.sv
// crossroad renderer types
// shared between the pipeline stages

package crossroad_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [7:0] channel_t;

    // red is the top bit
    typedef logic [2:0] lamp_t;
    typedef logic [3:0] bcd_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } scan_pos_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    typedef enum logic [2:0] {
        ROAD_BG,
        ROAD_SIDEWALK,
        ROAD_LANE,
        ROAD_ZEBRA,
        ROAD_CENTER
    } road_class_t;

    typedef struct packed {
        logic       car_hit;
        logic [1:0] car_id;
        logic       housing_hit;
        logic       core_hit;
        lamp_t      core_color;
    } object_hit_t;

    typedef struct packed {
        logic panel_hit;
        logic segment_hit;
    } hud_hit_t;

endpackage

//--- rtl/crossroad_renderer.sv
// crossroad traffic display renderer
// three-stage pixel pipeline: sample, classify, composite
`timescale 1ns/1ns

module crossroad_renderer (
    input  logic                   pixel_clk,
    input  logic                   rst_i,
    input  crossroad_pkg::coord_t  x_i,
    input  crossroad_pkg::coord_t  y_i,
    input  logic                   video_on_i,
    input  crossroad_pkg::lamp_t   light_ns_i,
    input  crossroad_pkg::lamp_t   light_ew_i,
    input  crossroad_pkg::bcd_t    ns_tens_i,
    input  crossroad_pkg::bcd_t    ns_ones_i,
    input  crossroad_pkg::bcd_t    ew_tens_i,
    input  crossroad_pkg::bcd_t    ew_ones_i,
    input  crossroad_pkg::coord_t  car_n_y_i,
    input  crossroad_pkg::coord_t  car_s_y_i,
    input  crossroad_pkg::coord_t  car_w_x_i,
    input  crossroad_pkg::coord_t  car_e_x_i,
    output crossroad_pkg::rgb_t    rgb_o
);
    import crossroad_pkg::*;

    // stage 1
    scan_pos_t   s1_pos;
    logic        s1_video_on;
    lamp_t       s1_light_ns;
    lamp_t       s1_light_ew;
    bcd_t        s1_ns_tens;
    bcd_t        s1_ns_ones;
    bcd_t        s1_ew_tens;
    bcd_t        s1_ew_ones;
    coord_t      s1_car_n_y;
    coord_t      s1_car_s_y;
    coord_t      s1_car_w_x;
    coord_t      s1_car_e_x;

    // stage 2
    logic        s2_video_on;
    road_class_t s2_class;
    object_hit_t s2_obj;
    hud_hit_t    s2_hud;

    pixel_sampler u_sampler (
        .pixel_clk  (pixel_clk),
        .rst_i      (rst_i),
        .x_i        (x_i),
        .y_i        (y_i),
        .video_on_i (video_on_i),
        .light_ns_i (light_ns_i),
        .light_ew_i (light_ew_i),
        .ns_tens_i  (ns_tens_i),
        .ns_ones_i  (ns_ones_i),
        .ew_tens_i  (ew_tens_i),
        .ew_ones_i  (ew_ones_i),
        .car_n_y_i  (car_n_y_i),
        .car_s_y_i  (car_s_y_i),
        .car_w_x_i  (car_w_x_i),
        .car_e_x_i  (car_e_x_i),
        .pos_o      (s1_pos),
        .video_on_o (s1_video_on),
        .light_ns_o (s1_light_ns),
        .light_ew_o (s1_light_ew),
        .ns_tens_o  (s1_ns_tens),
        .ns_ones_o  (s1_ns_ones),
        .ew_tens_o  (s1_ew_tens),
        .ew_ones_o  (s1_ew_ones),
        .car_n_y_o  (s1_car_n_y),
        .car_s_y_o  (s1_car_s_y),
        .car_w_x_o  (s1_car_w_x),
        .car_e_x_o  (s1_car_e_x)
    );

    road_layer u_road (
        .pixel_clk (pixel_clk),
        .rst_i     (rst_i),
        .pos_i     (s1_pos),
        .class_o   (s2_class)
    );

    signal_car_layer u_objects (
        .pixel_clk  (pixel_clk),
        .rst_i      (rst_i),
        .pos_i      (s1_pos),
        .light_ns_i (s1_light_ns),
        .light_ew_i (s1_light_ew),
        .car_n_y_i  (s1_car_n_y),
        .car_s_y_i  (s1_car_s_y),
        .car_w_x_i  (s1_car_w_x),
        .car_e_x_i  (s1_car_e_x),
        .hit_o      (s2_obj)
    );

    hud_digits u_hud (
        .pixel_clk (pixel_clk),
        .rst_i     (rst_i),
        .pos_i     (s1_pos),
        .ns_tens_i (s1_ns_tens),
        .ns_ones_i (s1_ns_ones),
        .ew_tens_i (s1_ew_tens),
        .ew_ones_i (s1_ew_ones),
        .hit_o     (s2_hud)
    );

    // video_on keeps pace with the layer registers
    pixel_delay #(
        .T     (logic),
        .DEPTH (1)
    ) u_video_delay (
        .pixel_clk (pixel_clk),
        .rst_i     (rst_i),
        .data_i    (s1_video_on),
        .data_o    (s2_video_on)
    );

    pixel_compositor u_compositor (
        .pixel_clk  (pixel_clk),
        .rst_i      (rst_i),
        .video_on_i (s2_video_on),
        .class_i    (s2_class),
        .obj_i      (s2_obj),
        .hud_i      (s2_hud),
        .rgb_o      (rgb_o)
    );

endmodule

//--- rtl/crossroad_settings.svh
// crossroad renderer settings
// screen geometry, digit layout and colour constants

`ifndef CROSSROAD_SETTINGS_SVH
`define CROSSROAD_SETTINGS_SVH

// ========================================
// road geometry
// ========================================
`define V_ROAD_X_L     260
`define V_ROAD_X_R     380
`define H_ROAD_Y_T     180
`define H_ROAD_Y_B     300
`define SIDEWALK_W     16
`define STRIPE_PERIOD  12
`define STRIPE_WIDTH   6
`define CENTER_X_L     318
`define CENTER_X_R     322
`define CENTER_Y_T     238
`define CENTER_Y_B     242
`define SCREEN_CX      320
`define SCREEN_CY      240

// lane centres for the cars
`define V_LANE_W_X     290
`define V_LANE_E_X     350
`define H_LANE_N_Y     210
`define H_LANE_S_Y     270
`define CAR_LEN        20
`define CAR_WID        12

// ========================================
// traffic signals
// ========================================
`define TL_LONG        30
`define TL_SHORT       10
`define TL_SEG         10
`define TL_MARGIN      4
`define TLN_X          (`SCREEN_CX - (`TL_LONG / 2))
`define TLN_Y          (`H_ROAD_Y_T - `SIDEWALK_W - `TL_SHORT - `TL_MARGIN)
`define TLS_X          (`SCREEN_CX - (`TL_LONG / 2))
`define TLS_Y          (`H_ROAD_Y_B + `SIDEWALK_W + `TL_MARGIN)
`define TLW_X          (`V_ROAD_X_L - `SIDEWALK_W - `TL_SHORT - `TL_MARGIN)
`define TLW_Y          (`SCREEN_CY - (`TL_LONG / 2))
`define TLE_X          (`V_ROAD_X_R + `SIDEWALK_W + `TL_MARGIN)
`define TLE_Y          (`SCREEN_CY - (`TL_LONG / 2))

// ========================================
// HUD panel
// ========================================
`define HUD_X_MIN      500
`define HUD_X_MAX      640
`define HUD_Y_MAX      150
`define DIGIT_W        14
`define DIGIT_H        22
`define SEG_W          4
`define DIGIT_TENS_X   532
`define DIGIT_ONES_X   550
`define NS_ROW_Y       8
`define EW_ROW_Y       46

// pixel in to colour out, in clock edges
`define RENDER_LATENCY 3

// colour constants in r g b order
`define COL_BLANK      {8'd0, 8'd0, 8'd0}
`define COL_BG         {8'd6, 8'd10, 8'd18}
`define COL_SIDEWALK   {8'd70, 8'd80, 8'd95}
`define COL_LANE       {8'd24, 8'd24, 8'd26}
`define COL_ZEBRA      {8'd235, 8'd240, 8'd255}
`define COL_CENTER     {8'd20, 8'd180, 8'd200}
`define COL_CAR_N      {8'd40, 8'd90, 8'd220}
`define COL_CAR_S      {8'd200, 8'd60, 8'd220}
`define COL_CAR_W      {8'd240, 8'd120, 8'd30}
`define COL_CAR_E      {8'd60, 8'd220, 8'd160}
`define COL_HOUSING    {8'd28, 8'd28, 8'd30}
`define COL_RED        {8'd255, 8'd20, 8'd20}
`define COL_YELLOW     {8'd255, 8'd230, 8'd40}
`define COL_GREEN      {8'd30, 8'd255, 8'd80}
`define COL_HUD_BG     {8'd16, 8'd18, 8'd22}
`define COL_DIGIT      {8'd220, 8'd235, 8'd255}

`endif

//--- rtl/hud_digits.sv
// HUD layer
// panel box and seven-segment NS / EW countdowns
`timescale 1ns/1ns
`include "crossroad_settings.svh"

module hud_digits (
    input  logic                       pixel_clk,
    input  logic                       rst_i,
    input  crossroad_pkg::scan_pos_t   pos_i,
    input  crossroad_pkg::bcd_t        ns_tens_i,
    input  crossroad_pkg::bcd_t        ns_ones_i,
    input  crossroad_pkg::bcd_t        ew_tens_i,
    input  crossroad_pkg::bcd_t        ew_ones_i,
    output crossroad_pkg::hud_hit_t    hit_o
);
    import crossroad_pkg::*;

    hud_hit_t hit_d;

    // segment order a..g from bit 6 down to bit 0
    function automatic logic digit_pixel(input coord_t px, input coord_t py,
                                         input int dx, input int dy, input bcd_t digit);
        coord_t     rx;
        coord_t     ry;
        logic [6:0] pat;
        logic [6:0] seg;
        rx = coord_t'(px - dx);
        ry = coord_t'(py - dy);
        case (digit)
            4'd0:    pat = 7'b1111110;
            4'd1:    pat = 7'b0110000;
            4'd2:    pat = 7'b1101101;
            4'd3:    pat = 7'b1111001;
            4'd4:    pat = 7'b0110011;
            4'd5:    pat = 7'b1011011;
            4'd6:    pat = 7'b1011111;
            4'd7:    pat = 7'b1110000;
            4'd8:    pat = 7'b1111111;
            4'd9:    pat = 7'b1111011;
            default: pat = 7'b0000000;
        endcase
        // verticals overlap the corners so strokes join
        seg[6] = ry < `SEG_W;
        seg[5] = rx >= `DIGIT_W - `SEG_W && ry < `DIGIT_H / 2 + 1;
        seg[4] = rx >= `DIGIT_W - `SEG_W && ry >= `DIGIT_H / 2 - 1;
        seg[3] = ry >= `DIGIT_H - `SEG_W;
        seg[2] = rx < `SEG_W && ry >= `DIGIT_H / 2 - 1;
        seg[1] = rx < `SEG_W && ry < `DIGIT_H / 2 + 1;
        seg[0] = ry >= `DIGIT_H / 2 - `SEG_W / 2 - 1 && ry < `DIGIT_H / 2 + `SEG_W / 2 + 1;
        return rx < `DIGIT_W && ry < `DIGIT_H && |(pat & seg);
    endfunction

    always_comb begin
        hit_d.panel_hit   = pos_i.x >= `HUD_X_MIN && pos_i.x < `HUD_X_MAX &&
                            pos_i.y < `HUD_Y_MAX;
        hit_d.segment_hit =
            digit_pixel(pos_i.x, pos_i.y, `DIGIT_TENS_X, `NS_ROW_Y, ns_tens_i) ||
            digit_pixel(pos_i.x, pos_i.y, `DIGIT_ONES_X, `NS_ROW_Y, ns_ones_i) ||
            digit_pixel(pos_i.x, pos_i.y, `DIGIT_TENS_X, `EW_ROW_Y, ew_tens_i) ||
            digit_pixel(pos_i.x, pos_i.y, `DIGIT_ONES_X, `EW_ROW_Y, ew_ones_i);
    end

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            hit_o <= '0;
        end else begin
            hit_o <= hit_d;
        end
    end

endmodule

//--- rtl/pixel_compositor.sv
// output stage
// layer priority, blanking and the RGB register
`timescale 1ns/1ns
`include "crossroad_settings.svh"

module pixel_compositor (
    input  logic                        pixel_clk,
    input  logic                        rst_i,
    input  logic                        video_on_i,
    input  crossroad_pkg::road_class_t  class_i,
    input  crossroad_pkg::object_hit_t  obj_i,
    input  crossroad_pkg::hud_hit_t     hud_i,
    output crossroad_pkg::rgb_t         rgb_o
);
    import crossroad_pkg::*;

    rgb_t col;

    // lowest priority first
    always_comb begin
        case (class_i)
            ROAD_SIDEWALK: col = `COL_SIDEWALK;
            ROAD_LANE:     col = `COL_LANE;
            ROAD_ZEBRA:    col = `COL_ZEBRA;
            ROAD_CENTER:   col = `COL_CENTER;
            default:       col = `COL_BG;
        endcase
        if (obj_i.car_hit) begin
            case (obj_i.car_id)
                2'd0:    col = `COL_CAR_N;
                2'd1:    col = `COL_CAR_S;
                2'd2:    col = `COL_CAR_W;
                default: col = `COL_CAR_E;
            endcase
        end
        if (obj_i.housing_hit) begin
            col = `COL_HOUSING;
        end
        if (obj_i.core_hit) begin
            if (obj_i.core_color[2]) begin
                col = `COL_RED;
            end else if (obj_i.core_color[1]) begin
                col = `COL_YELLOW;
            end else begin
                col = `COL_GREEN;
            end
        end
        if (hud_i.panel_hit) begin
            col = `COL_HUD_BG;
        end
        if (hud_i.segment_hit) begin
            col = `COL_DIGIT;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            rgb_o <= `COL_BLANK;
        end else begin
            rgb_o <= video_on_i ? col : `COL_BLANK;
        end
    end

    // digits only ever sit inside the panel
    a_seg_in_panel: assert property (@(posedge pixel_clk) disable iff (rst_i)
        hud_i.segment_hit |-> hud_i.panel_hit)
        else $error("digit segment outside the HUD panel");

endmodule

//--- rtl/pixel_delay.sv
// fixed-depth delay line for any payload type
`timescale 1ns/1ns

module pixel_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic pixel_clk,
    input  logic rst_i,
    input  T     data_i,
    output T     data_o
);

    T stages [DEPTH];

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_o = stages[DEPTH-1];

    a_depth_min: assert property (@(posedge pixel_clk) DEPTH >= 1)
        else $error("pixel_delay needs at least one stage");

endmodule

//--- rtl/pixel_sampler.sv
// input stage of the renderer
// one snapshot of scan position and scene state per pixel
`timescale 1ns/1ns

module pixel_sampler (
    input  logic                      pixel_clk,
    input  logic                      rst_i,
    input  crossroad_pkg::coord_t     x_i,
    input  crossroad_pkg::coord_t     y_i,
    input  logic                      video_on_i,
    input  crossroad_pkg::lamp_t      light_ns_i,
    input  crossroad_pkg::lamp_t      light_ew_i,
    input  crossroad_pkg::bcd_t       ns_tens_i,
    input  crossroad_pkg::bcd_t       ns_ones_i,
    input  crossroad_pkg::bcd_t       ew_tens_i,
    input  crossroad_pkg::bcd_t       ew_ones_i,
    input  crossroad_pkg::coord_t     car_n_y_i,
    input  crossroad_pkg::coord_t     car_s_y_i,
    input  crossroad_pkg::coord_t     car_w_x_i,
    input  crossroad_pkg::coord_t     car_e_x_i,
    output crossroad_pkg::scan_pos_t  pos_o,
    output logic                      video_on_o,
    output crossroad_pkg::lamp_t      light_ns_o,
    output crossroad_pkg::lamp_t      light_ew_o,
    output crossroad_pkg::bcd_t       ns_tens_o,
    output crossroad_pkg::bcd_t       ns_ones_o,
    output crossroad_pkg::bcd_t       ew_tens_o,
    output crossroad_pkg::bcd_t       ew_ones_o,
    output crossroad_pkg::coord_t     car_n_y_o,
    output crossroad_pkg::coord_t     car_s_y_o,
    output crossroad_pkg::coord_t     car_w_x_o,
    output crossroad_pkg::coord_t     car_e_x_o
);
    import crossroad_pkg::*;

    scan_pos_t pos_in;

    assign pos_in.x = x_i;
    assign pos_in.y = y_i;

    pixel_delay #(
        .T     (scan_pos_t),
        .DEPTH (1)
    ) u_pos_delay (
        .pixel_clk (pixel_clk),
        .rst_i     (rst_i),
        .data_i    (pos_in),
        .data_o    (pos_o)
    );

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            video_on_o <= 1'b0;
            light_ns_o <= '0;
            light_ew_o <= '0;
            ns_tens_o  <= '0;
            ns_ones_o  <= '0;
            ew_tens_o  <= '0;
            ew_ones_o  <= '0;
            car_n_y_o  <= '0;
            car_s_y_o  <= '0;
            car_w_x_o  <= '0;
            car_e_x_o  <= '0;
        end else begin
            video_on_o <= video_on_i;
            light_ns_o <= light_ns_i;
            light_ew_o <= light_ew_i;
            ns_tens_o  <= ns_tens_i;
            ns_ones_o  <= ns_ones_i;
            ew_tens_o  <= ew_tens_i;
            ew_ones_o  <= ew_ones_i;
            car_n_y_o  <= car_n_y_i;
            car_s_y_o  <= car_s_y_i;
            car_w_x_o  <= car_w_x_i;
            car_e_x_o  <= car_e_x_i;
        end
    end

    // countdown digits are plain bcd
    a_bcd_range: assert property (@(posedge pixel_clk) disable iff (rst_i)
        ns_tens_i <= 4'd9 && ns_ones_i <= 4'd9 && ew_tens_i <= 4'd9 && ew_ones_i <= 4'd9)
        else $error("countdown digit out of bcd range");

    // a signal shows one lamp at a time while painting
    a_one_lamp: assert property (@(posedge pixel_clk) disable iff (rst_i)
        video_on_i |-> ($countones(light_ns_i) <= 1 && $countones(light_ew_i) <= 1))
        else $error("more than one lamp lit on a signal");

endmodule

//--- rtl/road_layer.sv
// road layer
// background, sidewalks, carriageways, zebra crossings and centre lines
`timescale 1ns/1ns
`include "crossroad_settings.svh"

module road_layer (
    input  logic                        pixel_clk,
    input  logic                        rst_i,
    input  crossroad_pkg::scan_pos_t    pos_i,
    output crossroad_pkg::road_class_t  class_o
);
    import crossroad_pkg::*;

    coord_t      px;
    coord_t      py;
    coord_t      x_off;
    coord_t      y_off;
    logic        in_v_road;
    logic        in_h_road;
    logic        v_walk;
    logic        h_walk;
    logic        on_center;
    road_class_t class_d;

    assign px = pos_i.x;
    assign py = pos_i.y;

    // stripe phase is taken from the near road edge
    assign x_off = coord_t'(px - `V_ROAD_X_L);
    assign y_off = coord_t'(py - `H_ROAD_Y_T);

    assign in_v_road = px >= `V_ROAD_X_L && px < `V_ROAD_X_R;
    assign in_h_road = py >= `H_ROAD_Y_T && py < `H_ROAD_Y_B;

    assign v_walk = (px >= `V_ROAD_X_L - `SIDEWALK_W && px < `V_ROAD_X_L) ||
                    (px >= `V_ROAD_X_R && px < `V_ROAD_X_R + `SIDEWALK_W);
    assign h_walk = (py >= `H_ROAD_Y_T - `SIDEWALK_W && py < `H_ROAD_Y_T) ||
                    (py >= `H_ROAD_Y_B && py < `H_ROAD_Y_B + `SIDEWALK_W);

    assign on_center = (px >= `CENTER_X_L && px < `CENTER_X_R) ||
                       (py >= `CENTER_Y_T && py < `CENTER_Y_B);

    // later tests win
    always_comb begin
        class_d = ROAD_BG;
        if (v_walk || h_walk) begin
            class_d = ROAD_SIDEWALK;
        end
        if (in_v_road || in_h_road) begin
            class_d = ROAD_LANE;
        end
        if (in_v_road && h_walk && (x_off % `STRIPE_PERIOD) < `STRIPE_WIDTH) begin
            class_d = ROAD_ZEBRA;
        end
        if (in_h_road && v_walk && (y_off % `STRIPE_PERIOD) < `STRIPE_WIDTH) begin
            class_d = ROAD_ZEBRA;
        end
        if (on_center) begin
            class_d = ROAD_CENTER;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            class_o <= ROAD_BG;
        end else begin
            class_o <= class_d;
        end
    end

endmodule

//--- rtl/signal_car_layer.sv
// car and traffic signal layer
// car bodies, signal housings and lit lamp cores
`timescale 1ns/1ns
`include "crossroad_settings.svh"

module signal_car_layer (
    input  logic                         pixel_clk,
    input  logic                         rst_i,
    input  crossroad_pkg::scan_pos_t     pos_i,
    input  crossroad_pkg::lamp_t         light_ns_i,
    input  crossroad_pkg::lamp_t         light_ew_i,
    input  crossroad_pkg::coord_t        car_n_y_i,
    input  crossroad_pkg::coord_t        car_s_y_i,
    input  crossroad_pkg::coord_t        car_w_x_i,
    input  crossroad_pkg::coord_t        car_e_x_i,
    output crossroad_pkg::object_hit_t   hit_o
);
    import crossroad_pkg::*;

    // housings in N, S, W, E order; W and E stand upright
    localparam int HOUSE_X [4] = '{`TLN_X, `TLS_X, `TLW_X, `TLE_X};
    localparam int HOUSE_Y [4] = '{`TLN_Y, `TLS_Y, `TLW_Y, `TLE_Y};
    localparam int HALF_W      = `CAR_WID / 2;

    object_hit_t hit_d;

    function automatic logic in_rect(input coord_t px, input coord_t py,
                                     input int x0, input int y0, input int w, input int h);
        return px >= x0 && px < x0 + w && py >= y0 && py < y0 + h;
    endfunction

    always_comb begin
        lamp_t lamp;
        logic  upright;
        int    cx;
        int    cy;
        hit_d = '0;
        // ========================================
        // cars where the last match gives the id
        // ========================================
        if (in_rect(pos_i.x, pos_i.y, `V_LANE_W_X - HALF_W, car_n_y_i, `CAR_WID, `CAR_LEN)) begin
            hit_d.car_hit = 1'b1;
            hit_d.car_id  = 2'd0;
        end
        if (in_rect(pos_i.x, pos_i.y, `V_LANE_E_X - HALF_W, car_s_y_i, `CAR_WID, `CAR_LEN)) begin
            hit_d.car_hit = 1'b1;
            hit_d.car_id  = 2'd1;
        end
        if (in_rect(pos_i.x, pos_i.y, car_w_x_i, `H_LANE_N_Y - HALF_W, `CAR_LEN, `CAR_WID)) begin
            hit_d.car_hit = 1'b1;
            hit_d.car_id  = 2'd2;
        end
        if (in_rect(pos_i.x, pos_i.y, car_e_x_i, `H_LANE_S_Y - HALF_W, `CAR_LEN, `CAR_WID)) begin
            hit_d.car_hit = 1'b1;
            hit_d.car_id  = 2'd3;
        end
        // ========================================
        // signal housings and cores
        // ========================================
        for (int h = 0; h < 4; h++) begin
            upright = (h >= 2);
            lamp    = upright ? light_ew_i : light_ns_i;
            if (in_rect(pos_i.x, pos_i.y, HOUSE_X[h], HOUSE_Y[h],
                        upright ? `TL_SHORT : `TL_LONG, upright ? `TL_LONG : `TL_SHORT)) begin
                hit_d.housing_hit = 1'b1;
            end
            // lamp cores from red to green, inset by one pixel in the housing
            for (int k = 0; k < 3; k++) begin
                cx = upright ? HOUSE_X[h] + 1 : HOUSE_X[h] + k * `TL_SEG + 1;
                cy = upright ? HOUSE_Y[h] + k * `TL_SEG + 1 : HOUSE_Y[h] + 1;
                if (lamp[2-k] && in_rect(pos_i.x, pos_i.y, cx, cy,
                                         `TL_SEG - 2, `TL_SHORT - 2)) begin
                    hit_d.core_hit   = 1'b1;
                    hit_d.core_color = lamp_t'(3'b100 >> k);
                end
            end
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (rst_i) begin
            hit_o <= '0;
        end else begin
            hit_o <= hit_d;
        end
    end

endmodule

//--- tests/tb_scene_checks.svh
// scene checks for the renderer testbench
// rgb compare and the colour rules for lamps and cars

`ifndef TB_SCENE_CHECKS_SVH
`define TB_SCENE_CHECKS_SVH

`include "crossroad_settings.svh"

task automatic check_rgb(input crossroad_pkg::rgb_t expected,
                         input crossroad_pkg::rgb_t actual,
                         input int row);
    if (actual !== expected) begin
        $display("FAILED at %0t ns: row %0d expected rgb %0d,%0d,%0d got %0d,%0d,%0d",
                 $time, row, expected.r, expected.g, expected.b,
                 actual.r, actual.g, actual.b);
        $display("Simulation failed");
        $fatal(1, "rgb mismatch on the renderer output");
    end
endtask

// lit core colour with red over yellow over green
function automatic crossroad_pkg::rgb_t lamp_colour(input crossroad_pkg::lamp_t lamp);
    if (lamp[2]) begin
        return `COL_RED;
    end else if (lamp[1]) begin
        return `COL_YELLOW;
    end else if (lamp[0]) begin
        return `COL_GREEN;
    end
    // only the housing shows when nothing is lit
    return `COL_HOUSING;
endfunction

// car body colour in N, S, W, E order
function automatic crossroad_pkg::rgb_t car_colour(input int dir);
    case (dir)
        0:       return `COL_CAR_N;
        1:       return `COL_CAR_S;
        2:       return `COL_CAR_W;
        default: return `COL_CAR_E;
    endcase
endfunction

`endif

//--- tests/tb_crossroad_renderer.sv
// testbench for the crossroad renderer
// probe table through the pixel pipeline at fixed latency
`timescale 1ns/1ns
`include "crossroad_settings.svh"

module tb_crossroad_renderer;
    import crossroad_pkg::*;

    `include "tb_scene_checks.svh"

    typedef struct {
        coord_t x;
        coord_t y;
        logic   video_on;
        lamp_t  light_ns;
        lamp_t  light_ew;
        bcd_t   ns_tens;
        bcd_t   ns_ones;
        bcd_t   ew_tens;
        bcd_t   ew_ones;
        coord_t car_n_y;
        coord_t car_s_y;
        coord_t car_w_x;
        coord_t car_e_x;
        rgb_t   expected;
    } probe_t;

    logic   pixel_clk;
    logic   rst_i;
    coord_t x_i;
    coord_t y_i;
    logic   video_on_i;
    lamp_t  light_ns_i;
    lamp_t  light_ew_i;
    bcd_t   ns_tens_i;
    bcd_t   ns_ones_i;
    bcd_t   ew_tens_i;
    bcd_t   ew_ones_i;
    coord_t car_n_y_i;
    coord_t car_s_y_i;
    coord_t car_w_x_i;
    coord_t car_e_x_i;
    rgb_t   rgb_o;

    probe_t probes[$];
    int     cycles = 0;
    int     timeout_limit = 1000;

    crossroad_renderer dut_i (
        .pixel_clk  (pixel_clk),
        .rst_i      (rst_i),
        .x_i        (x_i),
        .y_i        (y_i),
        .video_on_i (video_on_i),
        .light_ns_i (light_ns_i),
        .light_ew_i (light_ew_i),
        .ns_tens_i  (ns_tens_i),
        .ns_ones_i  (ns_ones_i),
        .ew_tens_i  (ew_tens_i),
        .ew_ones_i  (ew_ones_i),
        .car_n_y_i  (car_n_y_i),
        .car_s_y_i  (car_s_y_i),
        .car_w_x_i  (car_w_x_i),
        .car_e_x_i  (car_e_x_i),
        .rgb_o      (rgb_o)
    );

    always #10 pixel_clk = ~pixel_clk;

    always @(posedge pixel_clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            $display("timeout: probe table not finished after %0d cycles", cycles);
            $display("Simulation failed");
            $fatal(1, "renderer run exceeded its cycle limit");
        end
    end

    // quiet scene with the cars parked off screen
    function automatic probe_t default_probe(input coord_t x, input coord_t y,
                                             input rgb_t expected);
        probe_t p;
        p.x        = x;
        p.y        = y;
        p.video_on = 1'b1;
        p.light_ns = 3'b000;
        p.light_ew = 3'b000;
        p.ns_tens  = 4'd0;
        p.ns_ones  = 4'd0;
        p.ew_tens  = 4'd0;
        p.ew_ones  = 4'd0;
        p.car_n_y  = 10'd1000;
        p.car_s_y  = 10'd1000;
        p.car_w_x  = 10'd1000;
        p.car_e_x  = 10'd1000;
        p.expected = expected;
        return p;
    endfunction

    task automatic apply_probe(input probe_t p);
        x_i        = p.x;
        y_i        = p.y;
        video_on_i = p.video_on;
        light_ns_i = p.light_ns;
        light_ew_i = p.light_ew;
        ns_tens_i  = p.ns_tens;
        ns_ones_i  = p.ns_ones;
        ew_tens_i  = p.ew_tens;
        ew_ones_i  = p.ew_ones;
        car_n_y_i  = p.car_n_y;
        car_s_y_i  = p.car_s_y;
        car_w_x_i  = p.car_w_x;
        car_e_x_i  = p.car_e_x;
    endtask

    initial begin
        probe_t p;
        int     n;
        pixel_clk = 1'b0;
        rst_i     = 1'b1;
        p = default_probe(10'd0, 10'd0, `COL_BLANK);
        p.video_on = 1'b0;
        apply_probe(p);

        // ========================================
        // probe table
        // ========================================
        // blanking with one probe over a lit lamp
        p = default_probe(310, 155, `COL_BLANK);
        p.video_on = 1'b0;
        p.light_ns = 3'b100;
        probes.push_back(p);
        p = default_probe(10, 10, `COL_BLANK);
        p.video_on = 1'b0;
        probes.push_back(p);
        // road classes
        probes.push_back(default_probe(10, 10, `COL_BG));
        probes.push_back(default_probe(250, 50, `COL_SIDEWALK));
        probes.push_back(default_probe(300, 50, `COL_LANE));
        probes.push_back(default_probe(262, 170, `COL_ZEBRA));
        probes.push_back(default_probe(270, 170, `COL_LANE));
        probes.push_back(default_probe(320, 100, `COL_CENTER));
        // NS signal on the north housing
        p = default_probe(310, 155, lamp_colour(3'b100));
        p.light_ns = 3'b100;
        probes.push_back(p);
        p = default_probe(310, 155, `COL_HOUSING);
        p.light_ns = 3'b001;
        probes.push_back(p);
        p = default_probe(330, 155, lamp_colour(3'b001));
        p.light_ns = 3'b001;
        probes.push_back(p);
        p = default_probe(320, 155, lamp_colour(3'b010));
        p.light_ns = 3'b010;
        probes.push_back(p);
        // EW signal on the upright west housing
        p = default_probe(235, 230, lamp_colour(3'b100));
        p.light_ew = 3'b100;
        probes.push_back(p);
        p = default_probe(235, 230, `COL_HOUSING);
        p.light_ew = 3'b001;
        probes.push_back(p);
        p = default_probe(235, 250, lamp_colour(3'b001));
        p.light_ew = 3'b001;
        probes.push_back(p);
        // cars over the lanes and the same spot without a car
        p = default_probe(290, 70, car_colour(0));
        p.car_n_y = 10'd60;
        probes.push_back(p);
        probes.push_back(default_probe(290, 70, `COL_LANE));
        p = default_probe(350, 400, car_colour(1));
        p.car_s_y = 10'd390;
        probes.push_back(p);
        p = default_probe(430, 210, car_colour(2));
        p.car_w_x = 10'd420;
        probes.push_back(p);
        p = default_probe(100, 270, car_colour(3));
        p.car_e_x = 10'd90;
        probes.push_back(p);
        // HUD segments a and g of the NS digits and a of the EW ones digit
        p = default_probe(538, 9, `COL_DIGIT);
        p.ns_tens = 4'd8;
        probes.push_back(p);
        p = default_probe(538, 9, `COL_HUD_BG);
        p.ns_tens = 4'd1;
        probes.push_back(p);
        probes.push_back(default_probe(600, 100, `COL_HUD_BG));
        p = default_probe(557, 19, `COL_DIGIT);
        p.ns_ones = 4'd2;
        probes.push_back(p);
        probes.push_back(default_probe(557, 19, `COL_HUD_BG));
        p = default_probe(553, 47, `COL_DIGIT);
        p.ew_ones = 4'd7;
        probes.push_back(p);

        timeout_limit = 10 + probes.size() + `RENDER_LATENCY + 20;

        repeat (10) @(posedge pixel_clk);
        @(negedge pixel_clk);
        rst_i = 1'b0;
        // row -1 stands for the output straight out of reset
        check_rgb(`COL_BLANK, rgb_o, -1);

        // one row per cycle with each result three rising edges later
        for (n = 0; n < probes.size() + `RENDER_LATENCY; n++) begin
            @(negedge pixel_clk);
            if (n >= `RENDER_LATENCY) begin
                check_rgb(probes[n - `RENDER_LATENCY].expected, rgb_o,
                          n - `RENDER_LATENCY);
            end
            if (n < probes.size()) begin
                apply_probe(probes[n]);
            end else begin
                video_on_i = 1'b0;
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
+incdir+tests
rtl/crossroad_pkg.sv
rtl/pixel_delay.sv
rtl/pixel_sampler.sv
rtl/road_layer.sv
rtl/signal_car_layer.sv
rtl/hud_digits.sv
rtl/pixel_compositor.sv
rtl/crossroad_renderer.sv
tests/tb_crossroad_renderer.sv
